// ==== verilog/cpu_pkg.sv ====
// CPU issue package: instruction fields, opcodes, conditions and hazard structs.
`default_nettype none

package cpu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Basic field types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [3:0]  reg_idx_t;  // One of 16 registers.
	typedef logic [15:0] instr_t;    // Fixed 16-bit instruction word.

	localparam reg_idx_t R0            = 4'd0;   // Reads as zero.
	localparam reg_idx_t LINK_REGISTER = 4'd15;  // Written by branch with link.

	// Opcode in bits 15:12. Codes above op_io_out act as op_nop.
	typedef enum logic [3:0] {
		op_nop         = 4'h0,
		op_alu_rr      = 4'h1,  // rd = ra op rb.
		op_alu_ri      = 4'h2,  // rd = ra op imm4.
		op_alu_single  = 4'h3,  // rd = op rd.
		op_cmp         = 4'h4,  // Flags only.
		op_load        = 4'h5,
		op_store       = 4'h6,
		op_branch      = 4'h7,
		op_branch_link = 4'h8,
		op_io_in       = 4'h9,
		op_io_out      = 4'ha
	} opcode_e;

	// Branch condition shares the rd field.
	typedef enum logic [3:0] {
		cond_always = 4'h0,  // The only condition that ignores flags.
		cond_eq     = 4'h1,
		cond_ne     = 4'h2,
		cond_cs     = 4'h3,
		cond_cc     = 4'h4,
		cond_mi     = 4'h5,
		cond_pl     = 4'h6,
		cond_vs     = 4'h7,
		cond_vc     = 4'h8,
		cond_gt     = 4'h9,
		cond_ge     = 4'ha,
		cond_lt     = 4'hb,
		cond_le     = 4'hc
	} cond_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Structs passed between issue blocks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		reg_idx_t reg_a;  // R0 when unused.
		reg_idx_t reg_b;  // R0 when unused.
	} reg_sel_t;

	typedef struct packed {
		reg_idx_t dest;            // Register written, R0 for none.
		logic     modifies_flags;
	} hazard_info_t;

	typedef struct packed {
		logic hazard_1;
		logic hazard_2;
		logic hazard_3;
	} hazard_vec_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Field extraction
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic opcode_e opcode_of(input instr_t ins);
		return opcode_e'(ins[15:12]);
	endfunction

	function automatic reg_idx_t rd_of(input instr_t ins);
		return ins[11:8];
	endfunction

	function automatic reg_idx_t ra_of(input instr_t ins);
		return ins[7:4];
	endfunction

	function automatic reg_idx_t rb_of(input instr_t ins);
		return ins[3:0];  // Also the 4-bit immediate.
	endfunction

	function automatic cond_e cond_of(input instr_t ins);
		return cond_e'(ins[11:8]);
	endfunction

endpackage

`default_nettype wire

// ==== verilog/cpu_decode.sv ====
// CPU decode: picks the registers that the p0 instruction reads.
`timescale 1ns/1ns
`default_nettype none

module cpu_decode (
	input  cpu_pkg::instr_t   instruction,  // p0 slot instruction.
	output cpu_pkg::reg_sel_t sel           // Read selects for hazard check.
);

	cpu_pkg::opcode_e opcode;
	cpu_pkg::reg_idx_t rd;
	cpu_pkg::reg_idx_t ra;
	cpu_pkg::reg_idx_t rb;

	assign opcode = cpu_pkg::opcode_of(instruction);
	assign rd     = cpu_pkg::rd_of(instruction);
	assign ra     = cpu_pkg::ra_of(instruction);
	assign rb     = cpu_pkg::rb_of(instruction);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read port selection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		sel.reg_a = cpu_pkg::R0;
		sel.reg_b = cpu_pkg::R0;

		case (opcode)
			// Two register sources.
			cpu_pkg::op_alu_rr,
			cpu_pkg::op_cmp,
			cpu_pkg::op_store,
			cpu_pkg::op_io_out: begin
				sel.reg_a = ra;
				sel.reg_b = rb;  // Store data or second operand.
			end

			// Single source in ra, bits 3:0 are an immediate.
			cpu_pkg::op_alu_ri,
			cpu_pkg::op_load,
			cpu_pkg::op_io_in: begin
				sel.reg_a = ra;
			end

			// Branch target register, rd holds the condition.
			cpu_pkg::op_branch,
			cpu_pkg::op_branch_link: begin
				sel.reg_a = ra;
			end

			// Operates in place on rd.
			cpu_pkg::op_alu_single: begin
				sel.reg_a = rd;
			end

			default: begin
				sel.reg_a = cpu_pkg::R0;  // Nop and unused codes.
				sel.reg_b = cpu_pkg::R0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/cpu_hazard.sv ====
// CPU hazard: p0 write target and flag use, compared against stages p1 to p3.
`timescale 1ns/1ns
`default_nettype none

module cpu_hazard (
	input  logic                  clk,          // Clocks the checks below.
	input  logic                  reset,
	input  cpu_pkg::instr_t       instruction,  // p0 slot instruction.
	input  logic                  ins_valid,
	input  cpu_pkg::reg_sel_t     sel,          // Registers p0 reads.
	input  cpu_pkg::hazard_info_t stage1,
	input  cpu_pkg::hazard_info_t stage2,
	input  cpu_pkg::hazard_info_t stage3,
	output cpu_pkg::hazard_info_t info0,        // Travels down the pipe.
	output cpu_pkg::hazard_vec_t  hazards
);

	cpu_pkg::opcode_e  opcode;
	cpu_pkg::reg_idx_t dest0;
	logic              flags0;
	logic              uses_flags;

	assign opcode = cpu_pkg::opcode_of(instruction);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write target of p0
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		dest0 = cpu_pkg::R0;
		case (opcode)
			cpu_pkg::op_alu_rr,
			cpu_pkg::op_alu_ri,
			cpu_pkg::op_alu_single,
			cpu_pkg::op_load,
			cpu_pkg::op_io_in: begin
				dest0 = cpu_pkg::rd_of(instruction);
			end
			cpu_pkg::op_branch_link: begin
				dest0 = cpu_pkg::LINK_REGISTER;  // Return address.
			end
			default: begin
				dest0 = cpu_pkg::R0;  // Compare, store, out, plain branch.
			end
		endcase
	end

	// Flag writers and flag readers.
	always_comb begin
		flags0     = 1'b0;
		uses_flags = 1'b0;
		case (opcode)
			cpu_pkg::op_alu_rr,
			cpu_pkg::op_alu_ri,
			cpu_pkg::op_alu_single,
			cpu_pkg::op_cmp: begin
				flags0 = 1'b1;
			end
			cpu_pkg::op_branch,
			cpu_pkg::op_branch_link: begin
				uses_flags = (cpu_pkg::cond_of(instruction) != cpu_pkg::cond_always);
			end
			default: begin
				flags0     = 1'b0;
				uses_flags = 1'b0;
			end
		endcase
	end

	// An invalid slot exports a bubble.
	always_comb begin
		info0 = '0;
		if (ins_valid) begin
			info0.dest           = dest0;
			info0.modifies_flags = flags0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Hazard compare
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One stage against the p0 read set. R0 never matches.
	function automatic logic stage_hit(
		input cpu_pkg::reg_sel_t     s,
		input cpu_pkg::hazard_info_t st,
		input logic                  flag_read
	);
		return ((s.reg_a != cpu_pkg::R0) && (s.reg_a == st.dest)) ||
		       ((s.reg_b != cpu_pkg::R0) && (s.reg_b == st.dest)) ||
		       (flag_read && st.modifies_flags);
	endfunction

	always_comb begin
		hazards.hazard_1 = ins_valid && stage_hit(sel, stage1, uses_flags);
		hazards.hazard_2 = ins_valid && stage_hit(sel, stage2, uses_flags);
		hazards.hazard_3 = ins_valid && stage_hit(sel, stage3, uses_flags);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	a_no_hazard_without_valid: assert property (
		@(posedge clk) disable iff (reset)
		(hazards != '0) |-> ins_valid
	) else $error("hazard raised with no valid instruction");

	a_store_writes_nothing: assert property (
		@(posedge clk) disable iff (reset)
		(opcode == cpu_pkg::op_store) |-> (info0.dest == cpu_pkg::R0)
	) else $error("store exported a write register");

endmodule

`default_nettype wire

// ==== verilog/cpu_hazard_pipe.sv ====
// CPU hazard pipe: carries write and flag info from p1 to p3, bubbling on stall.
`timescale 1ns/1ns
`default_nettype none

module cpu_hazard_pipe (
	input  logic                  clk,
	input  logic                  reset,
	input  cpu_pkg::hazard_info_t info0,      // From the p0 hazard decode.
	input  logic                  ins_valid,
	input  logic                  stall,
	output cpu_pkg::hazard_info_t stage1,
	output cpu_pkg::hazard_info_t stage2,
	output cpu_pkg::hazard_info_t stage3
);

	cpu_pkg::hazard_info_t next1;
	logic                  issue;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 1 input select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign issue = ins_valid && !stall;  // p0 moves into p1.

	always_comb begin
		next1 = '0;  // Bubble.
		if (issue) begin
			next1 = info0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Shift register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The pipe drains every cycle, stall only stops new entries.
	always_ff @(posedge clk) begin
		if (reset) begin
			stage1 <= '0;
			stage2 <= '0;
			stage3 <= '0;
		end else begin
			stage3 <= stage2;  // Leaves the window next edge.
			stage2 <= stage1;
			stage1 <= next1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	a_bubble_after_stall: assert property (
		@(posedge clk) disable iff (reset)
		stall |=> (stage1 == '0)
	) else $error("stage1 not a bubble after stall");

endmodule

`default_nettype wire

// ==== verilog/cpu_issue.sv ====
// CPU issue stage top: read decode, hazard detect and hazard pipe driving stall.
`timescale 1ns/1ns
`default_nettype none

module cpu_issue (
	input  logic                 clk,
	input  logic                 reset,
	input  cpu_pkg::instr_t      instruction,        // Held by fetch on stall.
	input  logic                 ins_valid,
	output logic                 stall,
	output cpu_pkg::hazard_vec_t hazards,
	output logic                 issue_valid,        // p0 enters p1 this cycle.
	output cpu_pkg::instr_t      issue_instruction
);

	cpu_pkg::reg_sel_t     sel;
	cpu_pkg::hazard_info_t info0;
	cpu_pkg::hazard_info_t stage1;
	cpu_pkg::hazard_info_t stage2;
	cpu_pkg::hazard_info_t stage3;

	cpu_decode u_decode (
		.instruction (instruction),
		.sel         (sel)
	);

	cpu_hazard u_hazard (
		.clk         (clk),
		.reset       (reset),
		.instruction (instruction),
		.ins_valid   (ins_valid),
		.sel         (sel),
		.stage1      (stage1),
		.stage2      (stage2),
		.stage3      (stage3),
		.info0       (info0),
		.hazards     (hazards)
	);

	cpu_hazard_pipe u_pipe (
		.clk       (clk),
		.reset     (reset),
		.info0     (info0),
		.ins_valid (ins_valid),
		.stall     (stall),
		.stage1    (stage1),
		.stage2    (stage2),
		.stage3    (stage3)
	);

	assign stall             = |hazards;  // Any stage conflict.
	assign issue_valid       = ins_valid && !stall;
	assign issue_instruction = instruction;

	// Bubbles fill the pipe while stalled, so no stall outlives the window.
	a_stall_bounded: assert property (
		@(posedge clk) disable iff (reset)
		stall |-> ##[1:3] !stall
	) else $error("stall held longer than three cycles");

endmodule

`default_nettype wire

// ==== dv/tb_cpu_issue.sv ====
// CPU issue testbench: directed and LFSR hazard stimulus checked against a stage scoreboard.
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_issue;

	localparam int          CLK_PERIOD      = 4;
	localparam int          RANDOM_CYCLES   = 2000;
	localparam int          DIRECTED_CYCLES = 100;
	localparam int          WATCHDOG_NS     = (RANDOM_CYCLES + DIRECTED_CYCLES) * CLK_PERIOD + 400;
	localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1.

	logic                  clk = 1'b0;
	logic                  reset;
	cpu_pkg::instr_t       instruction;
	logic                  ins_valid;
	logic                  stall;
	cpu_pkg::hazard_vec_t  hazards;
	logic                  issue_valid;
	cpu_pkg::instr_t       issue_instruction;

	cpu_pkg::hazard_info_t exp_stage1;  // Scoreboard copy of p1.
	cpu_pkg::hazard_info_t exp_stage2;
	cpu_pkg::hazard_info_t exp_stage3;
	cpu_pkg::hazard_vec_t  exp_hazards;
	logic                  exp_stall;
	logic [31:0]           lfsr_state   = 32'h137e_0835;
	int                    sent_count   = 0;
	int                    issued_count = 0;

	cpu_issue uut (
		.clk               (clk),
		.reset             (reset),
		.instruction       (instruction),
		.ins_valid         (ins_valid),
		.stall             (stall),
		.hazards           (hazards),
		.issue_valid       (issue_valid),
		.issue_instruction (issue_instruction)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ISA rules and scoreboard
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// {first, second} register read, zero where nothing is read.
	function automatic logic [7:0] read_regs(input cpu_pkg::instr_t ins);
		case (cpu_pkg::opcode_e'(ins[15:12]))
			cpu_pkg::op_alu_rr, cpu_pkg::op_cmp,
			cpu_pkg::op_store, cpu_pkg::op_io_out:  return ins[7:0];
			cpu_pkg::op_alu_ri, cpu_pkg::op_load, cpu_pkg::op_io_in,
			cpu_pkg::op_branch, cpu_pkg::op_branch_link: return {ins[7:4], 4'h0};
			cpu_pkg::op_alu_single: return {ins[11:8], 4'h0};
			default: return 8'h00;
		endcase
	endfunction

	function automatic cpu_pkg::hazard_info_t write_info(input cpu_pkg::instr_t ins);
		cpu_pkg::hazard_info_t info;
		info = '0;
		case (cpu_pkg::opcode_e'(ins[15:12]))
			cpu_pkg::op_alu_rr, cpu_pkg::op_alu_ri, cpu_pkg::op_alu_single: begin
				info.dest           = ins[11:8];
				info.modifies_flags = 1'b1;
			end
			cpu_pkg::op_cmp:                    info.modifies_flags = 1'b1;
			cpu_pkg::op_load, cpu_pkg::op_io_in: info.dest = ins[11:8];
			cpu_pkg::op_branch_link:            info.dest = 4'd15;  // Link register.
			default:                            info = '0;
		endcase
		return info;
	endfunction

	function automatic logic reads_flags(input cpu_pkg::instr_t ins);
		return (ins[15:12] == cpu_pkg::op_branch || ins[15:12] == cpu_pkg::op_branch_link) &&
		       (ins[11:8] != 4'h0);  // Any condition but always.
	endfunction

	function automatic logic collides(input cpu_pkg::instr_t ins, input cpu_pkg::hazard_info_t st);
		logic [7:0] regs;
		regs = read_regs(ins);
		return (regs[7:4] != 4'h0 && regs[7:4] == st.dest) ||
		       (regs[3:0] != 4'h0 && regs[3:0] == st.dest) ||
		       (reads_flags(ins) && st.modifies_flags);
	endfunction

	always_comb begin
		exp_hazards = '0;
		if (ins_valid) begin
			exp_hazards.hazard_1 = collides(instruction, exp_stage1);
			exp_hazards.hazard_2 = collides(instruction, exp_stage2);
			exp_hazards.hazard_3 = collides(instruction, exp_stage3);
		end
	end

	assign exp_stall = |exp_hazards;

	always @(posedge clk) begin
		if (reset) begin
			exp_stage1 <= '0;
			exp_stage2 <= '0;
			exp_stage3 <= '0;
		end else begin
			exp_stage3 <= exp_stage2;
			exp_stage2 <= exp_stage1;
			exp_stage1 <= (ins_valid && !exp_stall) ? write_info(instruction) : '0;
			if (issue_valid)
				issued_count <= issued_count + 1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reporting and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic abort_run;
		$display("tests failed");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] expected,
	                               input logic [15:0] actual);
		$display("Error: time %0t, %s expected %h actual %h", $time, name, expected, actual);
		abort_run();
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		abort_run();
	endtask

	a_hazards: assert property (@(posedge clk) disable iff (reset) hazards == exp_hazards)
		else report_mismatch("hazards", $sampled(exp_hazards), $sampled(hazards));
	a_stall: assert property (@(posedge clk) disable iff (reset) stall == exp_stall)
		else report_mismatch("stall", $sampled(exp_stall), $sampled(stall));
	a_issue_valid: assert property (@(posedge clk) disable iff (reset)
		issue_valid == (ins_valid && !exp_stall))
		else report_mismatch("issue_valid", $sampled(ins_valid && !exp_stall),
		                     $sampled(issue_valid));
	a_issue_instruction: assert property (@(posedge clk) disable iff (reset)
		issue_valid |-> issue_instruction == instruction)
		else report_mismatch("issue_instruction", $sampled(instruction),
		                     $sampled(issue_instruction));
	a_stage_words: assert property (@(posedge clk) disable iff (reset)
		{uut.stage1, uut.stage2, uut.stage3} == {exp_stage1, exp_stage2, exp_stage3})
		else report_mismatch("stage words", $sampled({exp_stage1, exp_stage2, exp_stage3}),
		                     $sampled({uut.stage1, uut.stage2, uut.stage3}));
	a_quiet_when_idle: assert property (@(posedge clk) disable iff (reset)
		!ins_valid |-> !stall && hazards == '0)
		else report_problem("stall or a hazard bit raised with no valid instruction");
	a_bubble_after_stall: assert property (@(posedge clk) disable iff (reset)
		stall |=> uut.stage1 == '0)
		else report_problem("stage1 did not take a bubble after a stall");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? LFSR_TAPS : 32'h0);
	endfunction

	task automatic draw(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val        = {val[14:0], lfsr_state[0]};  // One step per bit.
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// Registers 0, 1, 2 and 15 only, so collisions are frequent.
	task automatic draw_reg(output logic [3:0] r);
		logic [15:0] v;
		draw(2, v);
		r = (v[1:0] == 2'd3) ? 4'd15 : v[3:0];
	endtask

	task automatic draw_instr(output cpu_pkg::instr_t ins);
		logic [15:0] op;
		logic [3:0]  rd;
		logic [3:0]  ra;
		logic [3:0]  rb;
		draw(4, op);
		draw_reg(rd);
		draw_reg(ra);
		draw_reg(rb);
		ins = {op[3:0] % 4'd11, rd, ra, rb};  // Valid opcodes only.
	endtask

	function automatic cpu_pkg::instr_t encode(input cpu_pkg::opcode_e op,
	                                           input logic [3:0] rd, ra, rb);
		return {op, rd, ra, rb};
	endfunction

	// Holds the instruction until it issues.
	task automatic present(input cpu_pkg::instr_t ins);
		int waited;
		waited      = 0;
		instruction <= ins;
		ins_valid   <= 1'b1;
		sent_count++;
		@(posedge clk);
		while (!issue_valid) begin
			waited++;
			if (waited > 6)
				report_problem("a held instruction did not issue within 6 cycles");
			@(posedge clk);
		end
	endtask

	task automatic idle(input int cycles);
		ins_valid <= 1'b0;
		repeat (cycles) @(posedge clk);
	endtask

	initial begin
		#(WATCHDOG_NS);
		report_problem("watchdog timer expired before the run completed");
	end

	initial begin
		cpu_pkg::instr_t next_ins;
		logic [15:0]     bits;
		int              drain;
		reset       = 1'b1;
		instruction = '0;
		ins_valid   = 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// Read after write at distance 1, 2, 3 and beyond.
		present(encode(cpu_pkg::op_alu_rr, 4'd1, 4'd2, 4'd3));
		present(encode(cpu_pkg::op_alu_rr, 4'd4, 4'd1, 4'd5));
		present(encode(cpu_pkg::op_load, 4'd6, 4'd0, 4'd0));
		present(encode(cpu_pkg::op_nop, 4'd0, 4'd0, 4'd0));
		present(encode(cpu_pkg::op_alu_ri, 4'd7, 4'd6, 4'd2));
		present(encode(cpu_pkg::op_io_in, 4'd8, 4'd0, 4'd0));
		idle(2);
		present(encode(cpu_pkg::op_store, 4'd0, 4'd9, 4'd8));
		present(encode(cpu_pkg::op_load, 4'd9, 4'd0, 4'd0));
		idle(3);
		present(encode(cpu_pkg::op_alu_ri, 4'd10, 4'd9, 4'd1));

		// R0 and instructions that write no register.
		present(encode(cpu_pkg::op_load, 4'd0, 4'd3, 4'd0));
		present(encode(cpu_pkg::op_alu_rr, 4'd11, 4'd0, 4'd0));
		present(encode(cpu_pkg::op_store, 4'd5, 4'd2, 4'd3));
		present(encode(cpu_pkg::op_cmp, 4'd5, 4'd2, 4'd3));
		present(encode(cpu_pkg::op_branch, cpu_pkg::cond_always, 4'd0, 4'd5));
		present(encode(cpu_pkg::op_alu_rr, 4'd12, 4'd5, 4'd5));
		idle(3);

		// Flag writers ahead of conditional and unconditional branches.
		present(encode(cpu_pkg::op_cmp, 4'd0, 4'd1, 4'd2));
		present(encode(cpu_pkg::op_branch, cpu_pkg::cond_eq, 4'd0, 4'd0));
		present(encode(cpu_pkg::op_alu_single, 4'd3, 4'd0, 4'd0));
		present(encode(cpu_pkg::op_branch, cpu_pkg::cond_always, 4'd0, 4'd0));
		present(encode(cpu_pkg::op_alu_ri, 4'd13, 4'd0, 4'd4));
		present(encode(cpu_pkg::op_branch_link, cpu_pkg::cond_lt, 4'd0, 4'd0));
		present(encode(cpu_pkg::op_alu_rr, 4'd14, 4'd0, 4'd0));
		idle(1);
		present(encode(cpu_pkg::op_branch, cpu_pkg::cond_ne, 4'd0, 4'd0));

		// Link register, a quiet slot holding an R15 reader, then a real reader.
		present(encode(cpu_pkg::op_branch_link, cpu_pkg::cond_always, 4'd0, 4'd0));
		instruction <= encode(cpu_pkg::op_alu_rr, 4'd2, 4'd15, 4'd15);
		idle(1);
		present(encode(cpu_pkg::op_io_out, 4'd0, 4'd15, 4'd1));
		idle(4);

		for (int cycle = 0; cycle < RANDOM_CYCLES; cycle++) begin
			if (!(ins_valid && stall)) begin  // Fetch holds while stalled.
				draw_instr(next_ins);
				draw(2, bits);
				instruction <= next_ins;
				ins_valid   <= (bits[1:0] != 2'd0);
				if (bits[1:0] != 2'd0)
					sent_count++;
			end
			@(posedge clk);
		end

		drain = 0;
		while (ins_valid && stall) begin
			drain++;
			if (drain > 6)
				report_problem("last random instruction stayed stalled");
			@(posedge clk);
		end
		idle(2);
		if (issued_count != sent_count) begin
			report_problem("number of issued instructions differs from number presented");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/cpu_pkg.sv
verilog/cpu_decode.sv
verilog/cpu_hazard.sv
verilog/cpu_hazard_pipe.sv
verilog/cpu_issue.sv
dv/tb_cpu_issue.sv

// ==== Makefile ====
TOP = tb_cpu_issue

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f
	verilator --lint-only --assert --top-module cpu_issue \
		verilog/cpu_pkg.sv verilog/cpu_decode.sv verilog/cpu_hazard.sv \
		verilog/cpu_hazard_pipe.sv verilog/cpu_issue.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
